// File: design/genclk_pkg.sv
/* Shared widths, vector typedefs, the oscillator-to-serializer word struct
   and the timing constants of the clock generator */

package genclk_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// Phase step and accumulator share one fixed-point scale, 2**32 = i_clk rate
	localparam int unsigned FREQ_W      = 32;
	localparam int unsigned PHASE_W     = 32;

	// One pattern word per word slot, one bit per i_clk cycle
	localparam int unsigned WORD_BITS   = 8;
	localparam int unsigned SLOT_W      = $clog2(WORD_BITS);

	// Meter gate window and the edge count it can hold
	// Worst case is one edge every two cycles, so half the window plus one
	localparam int unsigned GATE_CYCLES = 1024;
	localparam int unsigned GATE_W      = $clog2(GATE_CYCLES);
	localparam int unsigned EDGE_W      = 11;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [FREQ_W-1:0]    freq_t;
	typedef logic [PHASE_W-1:0]   phase_t;
	// Bit 7 leaves the pin first
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [SLOT_W-1:0]    slot_t;
	typedef logic [EDGE_W-1:0]    edge_cnt_t;
	typedef logic [GATE_W-1:0]    gate_cnt_t;

	// Word handed from the oscillator to the serializer
	typedef struct packed {
		word_t word;
		// Low while the oscillator was disabled
		logic  active;
	} genclk_word_s;

	//////////////////////////////////////////////////////////////////////
	// Slot and window positions
	//////////////////////////////////////////////////////////////////////

	// Word request one slot ahead of the load, load at the last slot
	localparam slot_t     SLOT_REQ  = slot_t'(WORD_BITS - 2);
	localparam slot_t     SLOT_LAST = slot_t'(WORD_BITS - 1);
	localparam gate_cnt_t GATE_LAST = gate_cnt_t'(GATE_CYCLES - 1);

endpackage

// File: design/genclk_nco.sv
/* Numerically controlled oscillator: phase accumulator, step register with
   pending write, and parallel generation of one 8-bit pattern word */

`timescale 1ns/100ps

module genclk_nco (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	// Step write from software
	input  genclk_pkg::freq_t         i_freq,
	input  logic                      i_freq_wr,
	// Word request from the serializer, synchronized enable
	input  logic                      i_word_req,
	input  logic                      i_en,
	output genclk_pkg::genclk_word_s  o_word
);

	// Accumulator and the step in use
	genclk_pkg::phase_t        phase_q;
	genclk_pkg::freq_t         step_q;

	// Step written by software, waiting for the next word boundary
	genclk_pkg::freq_t         pend_step_q;
	logic                      pend_vld_q;

	// Step that applies to the word being built
	genclk_pkg::freq_t         step_eff;
	// Running phase through the word, ends at phase plus eight steps
	genclk_pkg::phase_t        phase_run;
	genclk_pkg::word_t         word_nxt;

	genclk_pkg::genclk_word_s  word_q;

	//////////////////////////////////////////////////////////////////////
	// Word generation
	//////////////////////////////////////////////////////////////////////

	// A pending step takes effect for the very word built at this request
	// Bit 7-j is the MSB of phase + j*step
	always_comb begin
		step_eff  = pend_vld_q ? pend_step_q : step_q;
		phase_run = phase_q;
		for (int j = 0; j < genclk_pkg::WORD_BITS; j++) begin
			word_nxt[genclk_pkg::WORD_BITS-1-j] = phase_run[genclk_pkg::PHASE_W-1];
			phase_run = phase_run + step_eff;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////

	// Pending step payload, qualified by pend_vld_q
	always_ff @(posedge i_clk) begin
		if (i_freq_wr) begin
			pend_step_q <= i_freq;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase_q    <= '0;
			step_q     <= '0;
			pend_vld_q <= 1'b0;
			word_q     <= '0;
		end else begin
			if (i_word_req) begin
				// Step update happens even while disabled
				step_q <= step_eff;
				if (i_en) begin
					phase_q       <= phase_run;
					word_q.word   <= word_nxt;
					word_q.active <= 1'b1;
				end else begin
					// Phase frozen, so resume picks up where it stopped
					word_q.word   <= '0;
					word_q.active <= 1'b0;
				end
			end

			// A write in the request cycle itself waits for the next boundary
			// Back-to-back writes simply overwrite, the last one wins
			if (i_freq_wr) begin
				pend_vld_q <= 1'b1;
			end else if (i_word_req) begin
				pend_vld_q <= 1'b0;
			end
		end
	end

	assign o_word = word_q;

endmodule

// File: design/genclk_oserdes.sv
/* Behavioral 8:1 output serializer: two-stage enable register, word-slot
   counter with word request, and MSB-first shift register onto the pin */

`timescale 1ns/100ps

module genclk_oserdes (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	// Raw enable level
	input  logic                      i_en,
	// Word from the oscillator, valid from slot 7
	input  genclk_pkg::genclk_word_s  i_word,
	output logic                      o_word_req,
	output logic                      o_en_sync,
	output logic                      o_pin
);

	// Enable pipeline, bit 1 is the synchronized level
	logic [1:0]         en_q;
	// Bit position inside the current word slot
	genclk_pkg::slot_t  slot_q;
	// Remaining bits of the word being sent
	genclk_pkg::word_t  sr_q;
	logic               pin_q;

	// Word as loaded, forced low when inactive
	genclk_pkg::word_t  load_word;
	logic               slot_end;

	//////////////////////////////////////////////////////////////////////
	// Enable and slot timing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			en_q   <= 2'b00;
			slot_q <= '0;
		end else begin
			en_q   <= {en_q[0], i_en};
			// Free-running, wraps from 7 back to 0
			slot_q <= slot_q + 1'b1;
		end
	end

	// Request one slot early so the oscillator word is ready at slot 7
	assign o_word_req = (slot_q == genclk_pkg::SLOT_REQ);
	assign slot_end   = (slot_q == genclk_pkg::SLOT_LAST);
	assign o_en_sync  = en_q[1];

	//////////////////////////////////////////////////////////////////////
	// Shift register and pin
	//////////////////////////////////////////////////////////////////////

	// An inactive word still loads, pin idles low
	assign load_word = i_word.active ? i_word.word : '0;

	// At the slot end bit 7 goes straight to the pin register
	// and the rest waits in the shift register
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sr_q  <= '0;
			pin_q <= 1'b0;
		end else if (slot_end) begin
			pin_q <= load_word[genclk_pkg::WORD_BITS-1];
			sr_q  <= {load_word[genclk_pkg::WORD_BITS-2:0], 1'b0};
		end else begin
			pin_q <= sr_q[genclk_pkg::WORD_BITS-1];
			sr_q  <= {sr_q[genclk_pkg::WORD_BITS-2:0], 1'b0};
		end
	end

	assign o_pin = pin_q;

endmodule

// File: design/genclk_freq_meter.sv
/* Frequency meter: rising-edge detector on the output pin and an edge
   counter over a fixed gate window */

`timescale 1ns/100ps

module genclk_freq_meter (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	// Generated clock, already in the i_clk domain
	input  logic                   i_pin,
	output genclk_pkg::edge_cnt_t  o_edge_count,
	output logic                   o_count_valid
);

	// Pin from the previous cycle
	logic                   pin_q;
	// Position inside the gate window, restarts from reset release
	genclk_pkg::gate_cnt_t  gate_q;
	// Edges seen so far in this window
	genclk_pkg::edge_cnt_t  acc_q;

	genclk_pkg::edge_cnt_t  cnt_q;
	logic                   vld_q;

	logic                   rise;
	logic                   gate_end;
	// Count including the current cycle
	genclk_pkg::edge_cnt_t  total;

	//////////////////////////////////////////////////////////////////////
	// Edge detect and window
	//////////////////////////////////////////////////////////////////////

	assign rise     = i_pin & ~pin_q;
	assign gate_end = (gate_q == genclk_pkg::GATE_LAST);
	assign total    = acc_q + genclk_pkg::edge_cnt_t'(rise);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pin_q  <= 1'b0;
			gate_q <= '0;
			acc_q  <= '0;
		end else begin
			pin_q  <= i_pin;
			// Power-of-two window, wraps on its own
			gate_q <= gate_q + 1'b1;
			if (gate_end) begin
				acc_q <= '0;
			end else begin
				acc_q <= total;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result
	//////////////////////////////////////////////////////////////////////

	// Count held until the next window end, strobe lasts one cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_q <= '0;
			vld_q <= 1'b0;
		end else begin
			vld_q <= gate_end;
			if (gate_end) begin
				cnt_q <= total;
			end
		end
	end

	assign o_edge_count  = cnt_q;
	assign o_count_valid = vld_q;

endmodule

// File: design/genclk_top.sv
/* Programmable clock generator top: oscillator, output serializer and
   frequency meter */

`timescale 1ns/100ps

module genclk_top (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	// Output enable level
	input  logic                   i_en,
	// Step write, one-cycle strobe
	input  genclk_pkg::freq_t      i_freq,
	input  logic                   i_freq_wr,
	// Generated clock
	output logic                   o_pin,
	// Edges per gate window
	output genclk_pkg::edge_cnt_t  o_edge_count,
	output logic                   o_count_valid
);

	//////////////////////////////////////////////////////////////////////
	// Internal links
	//////////////////////////////////////////////////////////////////////

	// Serializer to oscillator
	logic                      word_req;
	logic                      en_sync;
	// Oscillator to serializer
	genclk_pkg::genclk_word_s  word_data;

	//////////////////////////////////////////////////////////////////////
	// Word source
	//////////////////////////////////////////////////////////////////////

	genclk_nco u_nco (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_freq     (i_freq),
		.i_freq_wr  (i_freq_wr),
		.i_word_req (word_req),
		.i_en       (en_sync),
		.o_word     (word_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Serializer, owns slot timing and enable sync
	//////////////////////////////////////////////////////////////////////

	genclk_oserdes u_oserdes (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_en       (i_en),
		.i_word     (word_data),
		.o_word_req (word_req),
		.o_en_sync  (en_sync),
		.o_pin      (o_pin)
	);

	//////////////////////////////////////////////////////////////////////
	// Rate check on the pin
	//////////////////////////////////////////////////////////////////////

	genclk_freq_meter u_meter (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_pin         (o_pin),
		.o_edge_count  (o_edge_count),
		.o_count_valid (o_count_valid)
	);

endmodule

// File: testbench/genclk_tb.sv
/* Testbench for the clock generator: clock, reset, LFSR stimulus, reference
   model of the pattern stream, pin comparison and frequency meter checks */

`timescale 1ns/100ps

module genclk_tb;

	// Upper bounds in cycles for each test, used for the watchdog
	localparam int unsigned LEN_RESET   = 3 + 40 + 2 + 24;
	localparam int unsigned LEN_STREAM  = 4 * 12 + 2 + 400;
	localparam int unsigned LEN_CHANGE  = 20 * 34;
	localparam int unsigned LEN_DISABLE = 4 * 96;
	localparam int unsigned LEN_METER   = 3 * (24 + 3 * genclk_pkg::GATE_CYCLES);
	localparam int unsigned TIMEOUT_CYCLES =
		(LEN_RESET + LEN_STREAM + LEN_CHANGE + LEN_DISABLE + LEN_METER) * 11 / 10;

	logic                   i_clk;
	logic                   i_rst_n;
	logic                   i_en;
	genclk_pkg::freq_t      i_freq;
	logic                   i_freq_wr;
	logic                   o_pin;
	genclk_pkg::edge_cnt_t  o_edge_count;
	logic                   o_count_valid;

	// Run statistics
	int                     errors = 0;
	int                     checks = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;
	int unsigned            cycle_cnt = 0;
	logic [31:0]            lfsr_q = 32'h75be8b3a;

	// Reference model state
	genclk_pkg::slot_t      m_slot;
	logic                   m_en_d1;
	logic                   m_en_d2;
	genclk_pkg::phase_t     m_phase;
	genclk_pkg::freq_t      m_step;
	genclk_pkg::freq_t      m_pend;
	logic                   m_pend_vld;
	// Word built at the request, and the word now on the pin
	genclk_pkg::word_t      m_word;
	genclk_pkg::word_t      m_tx;

	genclk_top uut (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_en          (i_en),
		.i_freq        (i_freq),
		.i_freq_wr     (i_freq_wr),
		.o_pin         (o_pin),
		.o_edge_count  (o_edge_count),
		.o_count_valid (o_count_valid)
	);

	// 100 ns period
	always #50 i_clk = ~i_clk;

	//////////////////////////////////////////////////////////////////////
	// Random source and reference rule
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// Bit 7-j is the top bit of phase + j*step
	function automatic genclk_pkg::word_t build_word(input genclk_pkg::phase_t phase,
			input genclk_pkg::freq_t step);
		genclk_pkg::word_t  w;
		genclk_pkg::phase_t p;
		for (int j = 0; j < 8; j++) begin
			p = phase + genclk_pkg::phase_t'(j) * step;
			w[7-j] = p[31];
		end
		return w;
	endfunction

	task automatic model_reset();
		m_slot     = '0;
		m_en_d1    = 1'b0;
		m_en_d2    = 1'b0;
		m_phase    = '0;
		m_step     = '0;
		m_pend     = '0;
		m_pend_vld = 1'b0;
		m_word     = '0;
		m_tx       = '0;
	endtask

	// Moves the model across one rising edge, using the inputs now applied
	task automatic model_advance();
		genclk_pkg::freq_t step_eff;
		// Slot 6, word request: pending step applies to this very word
		if (m_slot == 3'd6) begin
			step_eff   = m_pend_vld ? m_pend : m_step;
			m_step     = step_eff;
			m_pend_vld = 1'b0;
			if (m_en_d2) begin
				m_word  = build_word(m_phase, step_eff);
				m_phase = m_phase + (step_eff << 3);
			end else begin
				m_word  = '0;
			end
		end
		// Slot 7, load into the serializer
		if (m_slot == 3'd7) begin
			m_tx = m_word;
		end
		if (i_freq_wr) begin
			m_pend     = i_freq;
			m_pend_vld = 1'b1;
		end
		m_en_d2 = m_en_d1;
		m_en_d1 = i_en;
		m_slot  = m_slot + 3'd1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Pin comparison and watchdog
	//////////////////////////////////////////////////////////////////////

	// Falling edge, all signals settled
	always @(negedge i_clk) begin
		if (!i_rst_n) begin
			model_reset();
		end else begin
			checks++;
			if (o_pin !== m_tx[3'd7 - m_slot]) begin
				errors++;
				$display("ERROR %0t: o_pin is %b, expected %b in slot %0d", $time, o_pin,
					m_tx[3'd7 - m_slot], m_slot);
			end
			model_advance();
		end
	end

	always @(posedge i_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic idle(input int n);
		repeat (n) @(posedge i_clk);
	endtask

	task automatic write_value(input genclk_pkg::freq_t s);
		@(posedge i_clk);
		i_freq    <= s;
		i_freq_wr <= 1'b1;
		@(posedge i_clk);
		i_freq_wr <= 1'b0;
	endtask

	// Strobe held high, one new random step per cycle
	task automatic write_burst(input int n);
		for (int k = 0; k < n; k++) begin
			@(posedge i_clk);
			i_freq    <= rand_bits(32);
			i_freq_wr <= 1'b1;
		end
		@(posedge i_clk);
		i_freq_wr <= 1'b0;
	endtask

	task automatic set_enable(input logic v);
		@(posedge i_clk);
		i_en <= v;
	endtask

	task automatic check_quiet(input int n);
		repeat (n) begin
			@(negedge i_clk);
			checks++;
			if (o_pin !== 1'b0 || o_count_valid !== 1'b0 || o_edge_count !== '0) begin
				errors++;
				$display("ERROR %0t: outputs not idle, pin %b valid %b count %0d", $time,
					o_pin, o_count_valid, o_edge_count);
			end
		end
	endtask

	// Sits on the cycle where the count strobe is high
	task automatic wait_count();
		do @(negedge i_clk); while (o_count_valid !== 1'b1);
	endtask

	// Skips the window that holds the step change, then checks two full ones
	task automatic measure_step(input genclk_pkg::freq_t s);
		logic [63:0] prod;
		int          exp_cnt;
		int          got;
		int          tol;
		write_value(s);
		idle(16);
		wait_count();
		prod    = 64'(genclk_pkg::GATE_CYCLES) * 64'(s);
		exp_cnt = int'(prod[63:32]);
		tol     = (s == '0) ? 0 : 1;
		repeat (2) begin
			wait_count();
			got = int'(o_edge_count);
			checks++;
			if (got > exp_cnt + tol || got + tol < exp_cnt) begin
				errors++;
				$display("ERROR %0t: edge count %0d, expected %0d for step %h", $time, got,
					exp_cnt, s);
			end
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors != err_start) begin
			tests_failed++;
		end
		$display("Test %-24s %s (%0d errors)", name, (errors == err_start) ? "ok" : "failed",
			errors - err_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int err_start;
		i_clk     = 1'b0;
		i_rst_n   = 1'b0;
		i_en      = 1'b0;
		i_freq    = '0;
		i_freq_wr = 1'b0;
		repeat (3) @(posedge i_clk);
		i_rst_n <= 1'b1;

		// Nonzero step alone keeps the pin low
		err_start = errors;
		check_quiet(40);
		write_value(rand_bits(32));
		check_quiet(24);
		end_test("reset state", err_start);

		err_start = errors;
		repeat (4) begin
			write_value(rand_bits(32));
			idle(2 + int'(rand_bits(3)));
		end
		set_enable(1'b1);
		idle(400);
		end_test("exact bit stream", err_start);

		// Random slot positions, bursts of one to three writes
		err_start = errors;
		repeat (20) begin
			idle(int'(rand_bits(3)));
			write_burst(1 + int'(rand_bits(1)) + int'(rand_bits(1)));
			idle(8 + int'(rand_bits(4)));
		end
		end_test("word-boundary change", err_start);

		err_start = errors;
		repeat (4) begin
			idle(int'(rand_bits(3)));
			set_enable(1'b0);
			idle(40);
			set_enable(1'b1);
			idle(40);
		end
		end_test("disable and resume", err_start);

		// Steps kept below a quarter of the bit rate
		err_start = errors;
		measure_step(rand_bits(30));
		measure_step(rand_bits(30));
		measure_step('0);
		end_test("frequency meter", err_start);

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
			tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
design/genclk_pkg.sv
design/genclk_nco.sv
design/genclk_oserdes.sv
design/genclk_freq_meter.sv
design/genclk_top.sv
testbench/genclk_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = genclk_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass or fail comes from the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
